// ==== all.f ====
+incdir+.
trs_pkg.sv
spi_slave.sv
cmd_parser.sv
bp_slot.sv
bp_hit_encoder.sv
debug_ram.sv
reply_reg.sv
trs_dbg_top.sv
tb_clkgen.sv
tb_checker.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
  exit 0
fi
exit 1

// ==== tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

  import trs_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        sck;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  z80_bus_t    bus;
  logic [7:0]  z80_data;
  logic        halt;
  logic [2:0]  bp_idx;
  logic [31:0] rng;
  logic [7:0]  model_mem [int];  // keyed by 15-bit address
  logic [15:0] slot_addr [8];
  logic        slot_act [8];
  logic        bp_en;
  logic [14:0] addr_list [$];

  tb_clkgen clkgen_i (.clk(clk), .rst_n(rst_n));

  trs_dbg_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .sck      (sck),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .bus      (bus),
    .z80_data (z80_data),
    .halt     (halt),
    .bp_idx   (bp_idx)
  );

  tb_checker checker_i (
    .clk(clk), .sck(sck), .cs_n(cs_n), .miso(miso),
    .z80_data(z80_data), .halt(halt), .bp_idx(bp_idx)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // expected halt and lowest active matching slot from the model
  function automatic logic model_hit(input logic [15:0] a, output logic [2:0] idx);
    idx = 3'd0;
    for (int i = 7; i >= 0; i--) begin
      if (slot_act[i] && slot_addr[i] == a)
        idx = 3'(i);
    end
    for (int i = 0; i < 8; i++) begin
      if (slot_act[i] && slot_addr[i] == a)
        return bp_en;
    end
    return 1'b0;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
  endtask

  // one mode 0 byte frame with an sck half period of 8 clk
  task automatic spi_xfer(input logic [7:0] b);
    cs_n <= 1'b0;
    tick(8);
    for (int i = 7; i >= 0; i--) begin
      mosi <= b[i];
      tick(8);
      sck <= 1'b1;
      tick(8);
      sck <= 1'b0;
    end
    tick(8);
    cs_n <= 1'b1;
    tick(8);
  endtask

  task automatic read_reply(input string name, input logic [7:0] exp);
    spi_xfer(8'hff);  // unknown opcode that the parser drops
    checker_i.check_reply(name, exp);
  endtask

  task automatic poke(input logic [14:0] a, input logic [7:0] d);
    spi_xfer(8'd1);
    spi_xfer(a[7:0]);
    spi_xfer({1'b0, a[14:8]});
    spi_xfer(d);
  endtask

  task automatic peek_check(input logic [14:0] a);
    spi_xfer(8'd2);
    spi_xfer(a[7:0]);
    spi_xfer({1'b0, a[14:8]});
    read_reply($sformatf("bram_peek %04h", a), model_mem[int'(a)]);
  endtask

  task automatic set_bp(input logic [2:0] s, input logic [15:0] a);
    spi_xfer(8'd6);
    spi_xfer({5'd0, s});
    spi_xfer(a[7:0]);
    spi_xfer(a[15:8]);
    slot_addr[s] = a;
    slot_act[s]  = 1'b1;
  endtask

  task automatic clear_bp(input logic [2:0] s);
    spi_xfer(8'd7);
    spi_xfer({5'd0, s});
    slot_act[s] = 1'b0;
  endtask

  // z80_data is due 5 cycles after rd_n falls
  task automatic z80_read(input logic [15:0] a);
    bus.addr <= a;
    bus.rd_n <= 1'b0;
    tick(6);
    bus.rd_n <= 1'b1;
  endtask

  task automatic z80_write(input logic [15:0] a, input logic [7:0] d);
    bus.addr <= a;
    bus.data <= d;
    bus.wr_n <= 1'b0;
    tick(6);
    bus.wr_n <= 1'b1;
    tick(2);
  endtask

  task automatic wait_halt(input logic exp, input string what);
    for (int i = 0; i < 20; i++) begin
      if (halt === exp)
        break;
      @(posedge clk);
    end
    if (halt !== exp)
      abort_run($sformatf("timeout: halt never went %0d %s", exp, what));
  endtask

  // read an address and check halt against the model and resume on a trip
  task automatic read_expect(input logic [15:0] a, input bit frozen_write);
    logic [2:0] idx;
    logic       hit;
    string      name;
    hit  = model_hit(a, idx);
    name = $sformatf("bp read %04h", a);
    z80_read(a);
    if (hit) begin
      wait_halt(1'b1, "after a breakpoint read");
      checker_i.check_halt(name, 1'b1, idx);
      if (frozen_write && addr_list.size() > 0) begin
        z80_write({1'b0, addr_list[0]}, ~model_mem[int'(addr_list[0])]);
        peek_check(addr_list[0]);  // model unchanged
      end
      spi_xfer(8'd13);
      checker_i.check_halt({name, " resumed"}, 1'b0, 3'd0);
    end else begin
      tick(4);
      checker_i.check_halt(name, 1'b0, 3'd0);
    end
    tick(2);
  endtask

  initial begin
    logic [14:0] a;
    logic [15:0] a16;
    logic [7:0]  d;
    logic [2:0]  s;
    logic [2:0]  dummy_idx;
    bit          first;
    rng   = 32'd46;
    bp_en = 1'b0;
    for (int i = 0; i < 8; i++) begin
      slot_act[i]  = 1'b0;
      slot_addr[i] = 16'h0;
    end
    sck  = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    bus  = '{addr: 16'h0, rd_n: 1'b1, wr_n: 1'b1, data: 8'h00};
    for (int i = 0; i < 20 && rst_n !== 1'b1; i++)
      @(posedge clk);
    if (rst_n !== 1'b1)
      abort_run("timeout: reset was never released");
    tick(2);

    spi_xfer(8'd0);
    read_reply("get_cookie", 8'haf);
    spi_xfer(8'd15);
    read_reply("get_version", 8'h03);

    // every fourth poke reuses an earlier address
    for (int i = 0; i < 20; i++) begin
      if (i % 4 == 3)
        a = addr_list[next_rand() % addr_list.size()];
      else
        a = 15'(next_rand());
      d = 8'(next_rand());
      poke(a, d);
      model_mem[int'(a)] = d;
      addr_list.push_back(a);
    end
    foreach (addr_list[i])
      peek_check(addr_list[i]);

    for (int i = 0; i < 4; i++) begin
      a16 = 16'(next_rand());
      bus.addr <= a16;
      tick(2);
      spi_xfer(8'd18);
      read_reply($sformatf("abus_read %04h", a16), a16[7:0]);
    end

    // bit 15 is random since memory mirrors above 32 KiB
    for (int i = 0; i < 4; i++) begin
      a16 = 16'(next_rand());
      d   = 8'(next_rand());
      z80_write(a16, d);
      model_mem[int'(a16[14:0])] = d;
      peek_check(a16[14:0]);
    end
    for (int i = 0; i < 4; i++) begin
      a16 = 16'(next_rand());
      d   = 8'(next_rand());
      poke(a16[14:0], d);
      model_mem[int'(a16[14:0])] = d;
      z80_read(a16);
      checker_i.check_z80_data($sformatf("z80 read %04h", a16), d);
      tick(2);
    end

    spi_xfer(8'd11);
    bp_en = 1'b1;
    for (int i = 0; i < 4; i++) begin
      s   = 3'(next_rand() % 8);
      a16 = 16'(next_rand());
      set_bp(s, a16);
    end
    a16 = 16'(next_rand());
    set_bp(3'd6, a16);  // same address in two slots where slot 2 must win
    set_bp(3'd2, a16);
    first = 1'b1;
    for (int i = 0; i < 8; i++) begin
      if (slot_act[i]) begin
        read_expect(slot_addr[i], first);
        first = 1'b0;
      end
    end
    a16 = 16'(next_rand());
    while (model_hit(a16, dummy_idx))
      a16 = 16'(next_rand());
    read_expect(a16, 1'b0);

    clear_bp(3'd2);
    clear_bp(3'd6);
    read_expect(slot_addr[2], 1'b0);
    spi_xfer(8'd12);
    bp_en = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (slot_act[i])
        read_expect(slot_addr[i], 1'b0);
    end

    tick(4);
    $display("tests %0d, passed %0d, failed %0d",
             checker_i.pass_cnt + checker_i.fail_cnt, checker_i.pass_cnt, checker_i.fail_cnt);
    if (checker_i.fail_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
  input logic       clk,
  input logic       sck,
  input logic       cs_n,
  input logic       miso,
  input logic [7:0] z80_data,
  input logic       halt,
  input logic [2:0] bp_idx
);

  int         pass_cnt = 0;
  int         fail_cnt = 0;
  logic       sck_q = 1'b0;
  logic [7:0] miso_byte = 8'h00;  // last eight bits seen on miso

  // master side of mode 0, sample miso on rising sck
  always @(posedge clk) begin
    sck_q <= sck;
    if (!cs_n && sck && !sck_q)
      miso_byte <= {miso_byte[6:0], miso};
  end

  task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      fail_cnt++;
      $display("ERROR %s expected %02h actual %02h", name, exp, act);
    end else begin
      pass_cnt++;
      $display("ok    %s = %02h", name, act);
    end
  endtask

  task automatic check_reply(input string name, input logic [7:0] exp);
    compare(name, exp, miso_byte);
  endtask

  task automatic check_z80_data(input string name, input logic [7:0] exp);
    compare(name, exp, z80_data);
  endtask

  // halt in bit 7, slot index below, index only counts while halted
  task automatic check_halt(input string name, input logic exp_halt, input logic [2:0] exp_idx);
    logic [7:0] exp;
    logic [7:0] act;
    exp = exp_halt ? {5'b10000, exp_idx} : 8'h00;
    act = halt ? {5'b10000, bp_idx} : {7'd0, halt};
    compare(name, exp, act);
  endtask

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;  // released on an edge, sync reset
  end

endmodule

// ==== trs_dbg_top.sv ====
`timescale 1ns/1ps
`include "trs_params.svh"

module trs_dbg_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sck,
  input  logic              cs_n,
  input  logic              mosi,
  output logic              miso,
  input  trs_pkg::z80_bus_t bus,
  output logic [7:0]        z80_data,
  output logic              halt,
  output logic [2:0]        bp_idx
);

  import trs_pkg::*;

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic [7:0] tx_byte;
  cmd_t       cmd;       // fans out to every consumer
  bp_match_t  bp_match;
  logic       rd_edge;
  logic [7:0] peek_data;
  logic       peek_valid;

  spi_slave spi_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .sck      (sck),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .tx_byte  (tx_byte)
  );

  cmd_parser parser_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .cmd      (cmd)
  );

  // one comparator per slot, index doubles as slot id
  for (genvar i = 0; i < `NUM_BP; i++) begin : g_bp
    bp_slot slot_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd     (cmd),
      .slot_id (3'(i)),
      .addr    (bus.addr),
      .match   (bp_match[i])
    );
  end

  bp_hit_encoder enc_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .bp_match (bp_match),
    .rd_edge  (rd_edge),
    .halt     (halt),
    .bp_idx   (bp_idx)
  );

  debug_ram ram_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (bus),
    .halt       (halt),
    .cmd        (cmd),
    .rd_edge    (rd_edge),
    .z80_data   (z80_data),
    .peek_data  (peek_data),
    .peek_valid (peek_valid)
  );

  reply_reg reply_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .peek_data   (peek_data),
    .peek_valid  (peek_valid),
    .z80_addr_lo (bus.addr[7:0]),
    .tx_byte     (tx_byte)
  );

endmodule

// ==== reply_reg.sv ====
`timescale 1ns/1ps
`include "trs_params.svh"

module reply_reg (
  input  logic          clk,
  input  logic          rst_n,
  input  trs_pkg::cmd_t cmd,
  input  logic [7:0]    peek_data,
  input  logic          peek_valid,
  input  logic [7:0]    z80_addr_lo,
  output logic [7:0]    tx_byte
);

  import trs_pkg::*;

  // byte shifted out on the next spi frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_byte <= '0;
    end else if (peek_valid) begin
      tx_byte <= peek_data;  // late memory answer
    end else if (cmd.valid) begin
      case (cmd.op)
        cmd_get_cookie:  tx_byte <= `COOKIE;
        cmd_get_version: tx_byte <= {`VERSION_MAJOR, `VERSION_MINOR};
        cmd_abus_read:   tx_byte <= z80_addr_lo;  // live bus snapshot
        default: ;  // everything else keeps the last reply
      endcase
    end
  end

endmodule

// ==== debug_ram.sv ====
`timescale 1ns/1ps
`include "trs_params.svh"

module debug_ram (
  input  logic              clk,
  input  logic              rst_n,
  input  trs_pkg::z80_bus_t bus,
  input  logic              halt,
  input  trs_pkg::cmd_t     cmd,
  output logic              rd_edge,
  output logic [7:0]        z80_data,
  output logic [7:0]        peek_data,
  output logic              peek_valid
);

  import trs_pkg::*;

  logic [7:0]         mem [2**`RAM_AW];
  logic [2:0]         rd_s;       // rd_n sync plus history
  logic [2:0]         wr_s;
  logic               wr_edge;
  logic               rd_pend;    // side A read in flight
  logic               peek_pend;
  logic [7:0]         ram_a_q;
  logic [7:0]         ram_b_q;
  logic [`RAM_AW-1:0] addr_a;
  logic [`RAM_AW-1:0] addr_b;
  logic               poke_en;
  logic               peek_en;

  assign addr_a  = `RAM_AW'(bus.addr);         // upper bit ignored, mirrors 32k
  assign addr_b  = `RAM_AW'({cmd.p1, cmd.p0});
  assign poke_en = cmd.valid && cmd.op == cmd_bram_poke;
  assign peek_en = cmd.valid && cmd.op == cmd_bram_peek;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_s       <= '1;  // strobes idle high
      wr_s       <= '1;
      rd_edge    <= 1'b0;
      wr_edge    <= 1'b0;
      rd_pend    <= 1'b0;
      peek_pend  <= 1'b0;
      peek_valid <= 1'b0;
      z80_data   <= '0;
    end else begin
      rd_s       <= {rd_s[1:0], bus.rd_n};
      wr_s       <= {wr_s[1:0], bus.wr_n};
      rd_edge    <= rd_s[2] & ~rd_s[1];  // falling rd_n
      wr_edge    <= wr_s[2] & ~wr_s[1];
      rd_pend    <= rd_edge & ~halt;
      peek_pend  <= peek_en;
      peek_valid <= peek_pend;
      if (rd_pend)
        z80_data <= ram_a_q;  // output stage
    end
  end

  // true dual port, A = z80, B = esp
  always_ff @(posedge clk) begin
    if (wr_edge && !halt)
      mem[addr_a] <= bus.data;  // frozen while halted
    if (rd_edge && !halt)
      ram_a_q <= mem[addr_a];
    if (poke_en)
      mem[addr_b] <= cmd.p2;
    if (peek_en)
      ram_b_q <= mem[addr_b];
  end

  assign peek_data = ram_b_q;  // held until next peek

endmodule

// ==== bp_hit_encoder.sv ====
`timescale 1ns/1ps
`include "trs_params.svh"

module bp_hit_encoder (
  input  logic               clk,
  input  logic               rst_n,
  input  trs_pkg::cmd_t      cmd,
  input  trs_pkg::bp_match_t bp_match,
  input  logic               rd_edge,
  output logic               halt,
  output logic [2:0]         bp_idx
);

  import trs_pkg::*;

  xray_state_e state;
  logic        bp_en;    // global breakpoint enable
  logic [2:0]  hit_idx;
  logic        hit_any;

  // lowest slot wins
  always_comb begin
    hit_idx = '0;
    for (int i = `NUM_BP - 1; i >= 0; i--) begin
      if (bp_match[i])
        hit_idx = 3'(i);
    end
  end

  assign hit_any = |bp_match;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= xray_run;
      bp_en  <= 1'b0;
      bp_idx <= '0;
    end else begin
      if (cmd.valid) begin
        case (cmd.op)
          cmd_enable_breakpoints:  bp_en <= 1'b1;
          cmd_disable_breakpoints: bp_en <= 1'b0;
          cmd_xray_resume:         state <= xray_run;  // no stub, release at once
          default: ;
        endcase
      end
      // only a read cycle can trip, and only while running
      if (rd_edge && state == xray_run && bp_en && hit_any) begin
        state  <= xray_stop;
        bp_idx <= hit_idx;
      end
    end
  end

  assign halt = (state == xray_stop);

endmodule

// ==== bp_slot.sv ====
`timescale 1ns/1ps

module bp_slot (
  input  logic          clk,
  input  logic          rst_n,
  input  trs_pkg::cmd_t cmd,
  input  logic [2:0]    slot_id,
  input  logic [15:0]   addr,
  output logic          match
);

  import trs_pkg::*;

  logic [15:0] bp_addr;
  logic        active;
  logic        mine;  // command addresses this slot

  assign mine = cmd.valid && (cmd.p0 == {5'd0, slot_id});

  always_ff @(posedge clk) begin
    if (!rst_n)
      active <= 1'b0;
    else if (mine && cmd.op == cmd_set_breakpoint)
      active <= 1'b1;
    else if (mine && cmd.op == cmd_clear_breakpoint)
      active <= 1'b0;  // address kept, just disarmed
  end

  always_ff @(posedge clk) begin
    if (mine && cmd.op == cmd_set_breakpoint)
      bp_addr <= {cmd.p2, cmd.p1};  // hi, lo
  end

  assign match = active && (addr == bp_addr);  // sampled by the encoder

endmodule

// ==== cmd_parser.sv ====
`timescale 1ns/1ps
`include "trs_params.svh"

module cmd_parser (
  input  logic          clk,
  input  logic          rst_n,
  input  logic [7:0]    rx_byte,
  input  logic          rx_valid,
  output trs_pkg::cmd_t cmd
);

  import trs_pkg::*;

  localparam int idx_w = $clog2(`MAX_PARAMS);

  parse_state_e     state;
  cmd_op_e          op_q;        // pending opcode, also the output op
  logic [2:0]       remaining;   // parameter bytes still expected
  logic [idx_w-1:0] idx;         // next buffer slot
  logic [7:0]       param_buf [`MAX_PARAMS];
  logic             valid_q;
  logic [7:0]       p0_q;
  logic [7:0]       p1_q;
  logic [7:0]       p2_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= parse_idle;
      op_q      <= cmd_get_cookie;
      remaining <= '0;
      idx       <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;  // strobe
      if (rx_valid) begin
        case (state)
          parse_idle: begin
            idx <= '0;
            case (rx_byte)
              cmd_get_cookie, cmd_get_version, cmd_abus_read,
              cmd_enable_breakpoints, cmd_disable_breakpoints, cmd_xray_resume: begin
                op_q    <= cmd_op_e'(rx_byte);
                valid_q <= 1'b1;  // no params, fire now
              end
              cmd_bram_poke, cmd_set_breakpoint: begin
                op_q      <= cmd_op_e'(rx_byte);
                remaining <= 3'd3;
                state     <= parse_read_bytes;
              end
              cmd_bram_peek: begin
                op_q      <= cmd_op_e'(rx_byte);
                remaining <= 3'd2;  // addr lo, addr hi
                state     <= parse_read_bytes;
              end
              cmd_clear_breakpoint: begin
                op_q      <= cmd_op_e'(rx_byte);
                remaining <= 3'd1;  // slot
                state     <= parse_read_bytes;
              end
              default: ;  // unknown opcode, drop it
            endcase
          end
          parse_read_bytes: begin
            idx       <= idx + idx_w'(1);
            remaining <= remaining - 3'd1;
            if (remaining == 3'd1) begin
              valid_q <= 1'b1;
              state   <= parse_idle;
            end
          end
          default: state <= parse_idle;
        endcase
      end
    end
  end

  // parameter bytes, the last one bypasses the buffer
  always_ff @(posedge clk) begin
    if (rx_valid && state == parse_read_bytes) begin
      param_buf[idx] <= rx_byte;
      p0_q <= (idx == idx_w'(0)) ? rx_byte : param_buf[0];
      p1_q <= (idx == idx_w'(1)) ? rx_byte : param_buf[1];
      p2_q <= (idx == idx_w'(2)) ? rx_byte : param_buf[2];
    end
  end

  assign cmd.valid = valid_q;
  assign cmd.op    = op_q;
  assign cmd.p0    = p0_q;
  assign cmd.p1    = p1_q;
  assign cmd.p2    = p2_q;

endmodule

// ==== spi_slave.sv ====
`timescale 1ns/1ps

module spi_slave (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  input  logic [7:0] tx_byte
);

  logic [2:0] sck_s;     // sck sync, [2] is edge history
  logic [2:0] cs_s;      // cs_n sync, same layout
  logic [1:0] mosi_s;    // mosi lines up with sck_s[1]
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_act;
  logic       frame_start;

  assign sck_rise    = (sck_s[2:1] == 2'b01);
  assign sck_fall    = (sck_s[2:1] == 2'b10);
  assign cs_act      = ~cs_s[1];
  assign frame_start = (cs_s[2:1] == 2'b10);  // cs_n falling

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_s  <= '0;
      cs_s   <= '1;  // deselected
      mosi_s <= '0;
    end else begin
      sck_s  <= {sck_s[1:0], sck};
      cs_s   <= {cs_s[1:0], cs_n};
      mosi_s <= {mosi_s[0], mosi};
    end
  end

  // receive side, mode 0 samples on rising sck
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_act && sck_rise && (bit_cnt == 3'd7);  // every byte reported
      if (!cs_act)
        bit_cnt <= '0;  // new frame starts at bit 0
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_act && sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_s[1]};  // msb first
  end

  assign rx_byte = rx_shift;  // stable until next rising sck

  // transmit side
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_shift <= '0;
    end else if (frame_start) begin
      tx_shift <= tx_byte;  // msb must sit on miso before first rise
    end else if (cs_act && sck_fall) begin
      if (bit_cnt == 3'd1)
        tx_shift <= {tx_byte[6:0], 1'b0};  // first fall, resample reply
      else
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign miso = cs_act ? tx_shift[7] : 1'b0;  // no tri-state, park low

endmodule

// ==== trs_pkg.sv ====
`include "trs_params.svh"

package trs_pkg;

  // opcodes as sent by the ESP
  typedef enum logic [7:0] {
    cmd_get_cookie          = 8'd0,
    cmd_bram_poke           = 8'd1,
    cmd_bram_peek           = 8'd2,
    cmd_set_breakpoint      = 8'd6,
    cmd_clear_breakpoint    = 8'd7,
    cmd_enable_breakpoints  = 8'd11,
    cmd_disable_breakpoints = 8'd12,
    cmd_xray_resume         = 8'd13,
    cmd_get_version         = 8'd15,
    cmd_abus_read           = 8'd18
  } cmd_op_e;

  typedef enum logic {
    parse_idle,
    parse_read_bytes
  } parse_state_e;

  typedef enum logic {
    xray_run,   // z80 free running
    xray_stop   // halted on a breakpoint
  } xray_state_e;

  // one finished command with a single-cycle valid strobe
  typedef struct packed {
    logic       valid;
    cmd_op_e    op;
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] p2;
  } cmd_t;

  // z80 bus as seen by the core with active low strobes
  typedef struct packed {
    logic [15:0] addr;
    logic        rd_n;
    logic        wr_n;
    logic [7:0]  data;
  } z80_bus_t;

  typedef logic [`NUM_BP-1:0] bp_match_t;  // one bit per slot

endpackage

// ==== trs_params.svh ====
`ifndef TRS_PARAMS_SVH
`define TRS_PARAMS_SVH

// identity byte answered to get_cookie
`define COOKIE 8'haf

// version byte is {major, minor}
`define VERSION_MAJOR 3'd0
`define VERSION_MINOR 5'd3

`define NUM_BP 8      // breakpoint slots
`define RAM_AW 15     // 32 KiB debug memory
`define MAX_PARAMS 4  // parameter buffer depth

`endif
